//--- design/video_pkg.sv
/*
 * Video timing constants for the object copy stage.
 * Pixel divider, line and frame totals, blanking window and the
 * line on which the object table copy is started each frame.
 */

package video_pkg;

    localparam int PXL_DIV   = 2;    // Clocks per pixel enable.
    localparam int CEN_W     = (PXL_DIV > 1) ? $clog2(PXL_DIV) : 1; // Divider width.

    localparam int H_TOTAL   = 128;  // Pixels per line.
    localparam int HDUMP_W   = $clog2(H_TOTAL); // Pixel counter width.

    localparam int V_TOTAL   = 262;  // Lines per frame.
    localparam int VDUMP_W   = 9;    // Line counter width.

    localparam int VB_START  = 240;  // First blanked line.
    localparam int VB_END    = 16;   // First active line.

    localparam int COPY_LINE = 64;   // Table copy begins here.

endpackage

//--- design/obj_pkg.sv
/*
 * Object attribute table geometry.
 * Table depth, copy slot length and the SDRAM address layout
 * used by the copy sequencer and the object frame buffer.
 */

package obj_pkg;

    localparam int OBJ_AW     = 10;            // Table word address width.
    localparam int OBJ_WORDS  = 1 << OBJ_AW;   // Words per bank.

    // One 16-bit word of the attribute table.
    typedef logic [15:0] obj_word_t;

    localparam int WORD_SLOTS = 17;            // Pixel enables per copied word.
    localparam int SLOT_W     = $clog2(WORD_SLOTS); // Slot counter width.

    // SDRAM address is the source bank bit above the word index.
    localparam int ORAM_AW    = OBJ_AW + 1;

endpackage

//--- design/video_timer.sv
/*
 * Video timer.
 * Divides the clock into the pixel enable, counts pixels and lines
 * and decodes a registered vertical blank from the line count.
 */

`timescale 1ns/1ps

module video_timer import video_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    output logic               pxl_cen,
    output logic [VDUMP_W-1:0] vdump,
    output logic               LVBL
);

    logic [CEN_W-1:0]   cen_cnt;    // Clock divider phase.
    logic [HDUMP_W-1:0] hdump;      // Pixel within line.
    logic               h_wrap;     // Last pixel of the line.

    assign h_wrap = pxl_cen && (hdump == HDUMP_W'(H_TOTAL - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            if (cen_cnt == CEN_W'(PXL_DIV - 1)) begin
                cen_cnt <= '0;
            end else begin
                cen_cnt <= cen_cnt + 1'b1;
            end
            pxl_cen <= (cen_cnt == CEN_W'(PXL_DIV - 1)); // One clock per period.
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
            LVBL  <= 1'b0;                       // Line 0 sits in blank.
        end else begin
            if (pxl_cen) begin
                hdump <= h_wrap ? '0 : hdump + 1'b1;
            end
            if (h_wrap) begin
                if (vdump == VDUMP_W'(V_TOTAL - 1)) begin
                    vdump <= '0;                 // Frame wrap.
                end else begin
                    vdump <= vdump + 1'b1;
                end
            end
            // Active between VB_END and VB_START.
            LVBL <= (vdump >= VDUMP_W'(VB_END)) && (vdump < VDUMP_W'(VB_START));
        end
    end

endmodule

//--- design/oram_copy_ctrl.sv
/*
 * Object table copy sequencer.
 * Flips the shown bank at each frame edge, then from COPY_LINE walks
 * the table one word per slot, reading SDRAM and strobing one buffer
 * write per word when the reply lands in time.
 */

`timescale 1ns/1ps

module oram_copy_ctrl import video_pkg::*, obj_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               pxl_cen,
    input  logic [VDUMP_W-1:0] vdump,
    input  logic               obank,
    output logic [ORAM_AW-1:0] oram_addr,
    output logic               oram_cs,
    output logic               oram_clr,
    input  logic               oram_ok,
    output logic [OBJ_AW-1:0]  wr_addr,
    output logic               oframe_we,
    output logic               obank_frame
);

    logic              frame;       // On line zero.
    logic              last_frame;
    logic              frame_edge;
    logic              copy_start;  // Copy line reached.
    logic              done;        // High while idle.
    logic [SLOT_W-1:0] slot_cnt;    // Pixel enables within word.
    logic [OBJ_AW-1:0] word_cnt;    // Table word index.
    logic              wtok;        // One write allowed per slot.
    logic              wr_hit;      // Reply accepted this clock.

    assign frame      = (vdump == '0);
    assign frame_edge = frame && !last_frame;
    assign copy_start = (vdump == VDUMP_W'(COPY_LINE));
    assign wr_hit     = !done && oram_ok && slot_cnt[0] && wtok; // Odd slots only.

    assign oram_addr  = {obank, word_cnt}; // Source half above index.
    assign oram_cs    = !done;
    assign oram_clr   = done;

    // Bank flip at the frame edge.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_frame  <= 1'b1;          // No flip straight out of reset.
            obank_frame <= 1'b0;
        end else begin
            last_frame <= frame;
            if (frame_edge) begin
                obank_frame <= !obank_frame;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done      <= 1'b1;
            slot_cnt  <= '0;
            word_cnt  <= '0;
            wtok      <= 1'b1;
            oframe_we <= 1'b0;
        end else if (done) begin
            slot_cnt  <= '0;
            word_cnt  <= '0;
            wtok      <= 1'b1;
            oframe_we <= 1'b0;
            if (copy_start) begin
                done <= 1'b0;             // Copy begins.
            end
        end else begin
            oframe_we <= wr_hit;          // Pulse one clock after reply.
            if (wr_hit) begin
                wtok <= 1'b0;
            end
            if (pxl_cen) begin
                if (slot_cnt == SLOT_W'(WORD_SLOTS - 1)) begin
                    slot_cnt <= '0;
                    wtok     <= 1'b1;     // Next word may write.
                    // Carry out of the index ends the copy.
                    {done, word_cnt} <= {1'b0, word_cnt} + (OBJ_AW + 1)'(1);
                end else begin
                    slot_cnt <= slot_cnt + 1'b1;
                end
            end
        end
    end

    // Write address captured with the accepted reply.
    always_ff @(posedge clk) begin
        if (wr_hit) begin
            wr_addr <= word_cnt;
        end
    end

endmodule

//--- design/obj_frame_buffer.sv
/*
 * Double-banked object frame buffer.
 * Both banks live in one memory indexed by bank bit and address.
 * SDRAM data is registered for the delayed write strobe; the
 * renderer reads the opposite bank through a registered port.
 */

`timescale 1ns/1ps

module obj_frame_buffer import obj_pkg::*; (
    input  logic              clk,
    input  logic              wr_bank,
    input  logic              we,
    input  logic [OBJ_AW-1:0] wr_addr,
    input  obj_word_t         wr_data,
    input  logic [OBJ_AW-1:0] rd_addr,
    output obj_word_t         rd_data
);

    obj_word_t mem [2*OBJ_WORDS];   // Bank bit on top.
    obj_word_t data_q;              // Aligns data with the write pulse.
    logic      rd_bank;

    assign rd_bank = !wr_bank;      // Renderer sees the other bank.

    always_ff @(posedge clk) begin
        data_q <= wr_data;
        if (we) begin
            mem[{wr_bank, wr_addr}] <= data_q;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[{rd_bank, rd_addr}]; // One clock read latency.
    end

endmodule

//--- design/obj_dma_top.sv
/*
 * Object table copy stage top level.
 * Connects the video timer, the copy sequencer and the
 * double-banked object frame buffer.
 */

`timescale 1ns/1ps

module obj_dma_top import video_pkg::*, obj_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               obank,
    output logic [ORAM_AW-1:0] oram_addr,
    output logic               oram_cs,
    output logic               oram_clr,
    input  logic               oram_ok,
    input  obj_word_t          oram_data,
    input  logic [OBJ_AW-1:0]  rd_addr,
    output obj_word_t          rd_data,
    output logic [VDUMP_W-1:0] vdump,
    output logic               LVBL,
    output logic               obank_frame
);

    logic              pxl_cen;     // Pixel enable.
    logic [OBJ_AW-1:0] wr_addr;     // Buffer write index.
    logic              oframe_we;   // Buffer write strobe.

    video_timer i_video_timer (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .vdump   (vdump),
        .LVBL    (LVBL)
    );

    oram_copy_ctrl i_oram_copy_ctrl (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .vdump       (vdump),
        .obank       (obank),
        .oram_addr   (oram_addr),
        .oram_cs     (oram_cs),
        .oram_clr    (oram_clr),
        .oram_ok     (oram_ok),
        .wr_addr     (wr_addr),
        .oframe_we   (oframe_we),
        .obank_frame (obank_frame)
    );

    obj_frame_buffer i_obj_frame_buffer (
        .clk     (clk),
        .wr_bank (obank_frame),     // Read bank derived inside.
        .we      (oframe_we),
        .wr_addr (wr_addr),
        .wr_data (oram_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- dv/obj_dma_assert.sv
/*
 * Copy sequencer protocol checks.
 * Bound onto the sequencer to watch the SDRAM strobes, the buffer
 * write pulse and the bank flip.
 */

`timescale 1ns/1ps

module obj_dma_assert import video_pkg::*, obj_pkg::*; (
    input logic               clk,
    input logic               rst,
    input logic               pxl_cen,
    input logic [VDUMP_W-1:0] vdump,
    input logic [ORAM_AW-1:0] oram_addr,
    input logic               oram_cs,
    input logic               oram_clr,
    input logic               oram_ok,
    input logic               oframe_we,
    input logic               obank_frame
);

    // Idle flag is the inverse of the chip select.
    cs_clr_complement: assert property (@(posedge clk) disable iff (rst)
        oram_cs != oram_clr)
        else $error("oram_cs and oram_clr are not complementary");

    // Write pulse comes one clock after an accepted reply.
    we_after_ok: assert property (@(posedge clk) disable iff (rst)
        oframe_we |-> $past(oram_ok))
        else $error("oframe_we without oram_ok on the clock before");

    // Flip only on the first clock of line zero.
    bank_on_edge: assert property (@(posedge clk) disable iff (rst)
        $changed(obank_frame) |-> ($past(vdump) == '0) && ($past(vdump, 2) != '0))
        else $error("obank_frame changed away from a frame edge");

    // Address steps only after a pixel enable.
    addr_in_slot: assert property (@(posedge clk) disable iff (rst)
        oram_cs && $past(oram_cs) && !$past(pxl_cen) |-> $stable(oram_addr))
        else $error("oram_addr moved inside a word slot");

endmodule

//--- dv/obj_dma_tb.sv
/*
 * Object table copy stage testbench.
 * Models the SDRAM reply with a per-frame latency and withheld range,
 * keeps its own copy of both banks and reads the buffer back a frame later.
 */

`timescale 1ns/1ps

module obj_dma_tb import video_pkg::*, obj_pkg::*; ();

    localparam int          CLK_PERIOD  = 4;
    localparam int          ROWS        = 6;
    localparam int          ROW_W       = $clog2(ROWS);
    localparam int          FRAME_CLKS  = V_TOTAL * H_TOTAL * PXL_DIV;
    localparam longint      WATCHDOG_NS = longint'(ROWS + 2) * FRAME_CLKS * CLK_PERIOD;
    localparam logic [31:0] SEED        = 32'h4c7f_d8d6;

    typedef struct packed {
        logic obank;    // Source half.
        int   lat;      // Reply latency in pixel enables.
        int   skip_lo;  // Withheld words, empty when lo > hi.
        int   skip_hi;
        logic writes;   // Expected to land in the buffer.
    } row_t;

    localparam row_t TABLE [ROWS] = '{
        '{1'b0, 1,  1,   0,    1'b1},   // Fills bank 0.
        '{1'b1, 2,  1,   0,    1'b1},   // Fills bank 1.
        '{1'b1, 3,  100, 355,  1'b1},
        '{1'b0, 0,  0,   15,   1'b1},
        '{1'b0, 20, 1,   0,    1'b0},   // Reply misses every slot.
        '{1'b1, 5,  900, 1023, 1'b1}
    };

    logic               clk;
    logic               rst;
    logic               obank;
    logic [ORAM_AW-1:0] oram_addr;
    logic               oram_cs;
    logic               oram_clr;
    logic               oram_ok   = 1'b0;
    obj_word_t          oram_data = '0;
    logic [OBJ_AW-1:0]  rd_addr;
    obj_word_t          rd_data;
    logic [VDUMP_W-1:0] vdump;
    logic               LVBL;
    logic               obank_frame;

    obj_word_t          exp_mem [2*OBJ_WORDS];  // Bank bit on top.
    logic [ORAM_AW-1:0] last_addr = '0;
    int                 wait_clks = 0;          // Clocks since address settled.
    int                 cur_lat;
    int                 cur_lo;
    int                 cur_hi;
    row_t               cur_row;
    int                 checks;
    int                 errors;
    int                 frame_errs;
    int                 frame_no;

    obj_dma_top i_obj_dma_top (.*);

    bind oram_copy_ctrl obj_dma_assert i_obj_dma_assert (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .vdump(vdump), .oram_addr(oram_addr),
        .oram_cs(oram_cs), .oram_clr(oram_clr), .oram_ok(oram_ok),
        .oframe_we(oframe_we), .obank_frame(obank_frame)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // SDRAM contents as a rule on the full address.
    function automatic obj_word_t rule_data(input logic [ORAM_AW-1:0] addr);
        logic [31:0] state;
        state = lcg_step(SEED ^ 32'(addr));
        state = lcg_step(state);
        return state[15:0];
    endfunction

    function automatic logic in_range(input int idx, input int lo, input int hi);
        return (idx >= lo) && (idx <= hi);
    endfunction

    task automatic check_word(input string name, input obj_word_t got, input obj_word_t exp);
        checks++;
        if (got !== exp) begin
            frame_errs++;
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            frame_errs++;
            errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input logic [VDUMP_W-1:0] got,
                              input logic [VDUMP_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            frame_errs++;
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic wait_frame_edge();
        logic prev;
        prev = obank_frame;
        do @(negedge clk); while (obank_frame == prev);
    endtask

    // Blank level is decoded from the line count a clock later.
    task automatic wait_blank_edge(input logic level, input logic [VDUMP_W-1:0] line);
        do @(negedge clk); while (LVBL !== level);
        check_line("vdump", vdump, line);
    endtask

    // Drive one row and fold its expected writes into the bank model.
    task automatic start_row(input int r);
        logic              bank;
        logic [OBJ_AW-1:0] idx;
        bank    = 1'(r % 2);
        cur_row = TABLE[ROW_W'(r)];
        @(posedge clk);
        obank  <= cur_row.obank;
        cur_lat <= cur_row.lat;
        cur_lo  <= cur_row.skip_lo;
        cur_hi  <= cur_row.skip_hi;
        for (int i = 0; i < OBJ_WORDS; i++) begin
            idx = OBJ_AW'(i);
            if (cur_row.writes && !in_range(i, cur_row.skip_lo, cur_row.skip_hi)) begin
                exp_mem[{bank, idx}] = rule_data({cur_row.obank, idx});
            end
        end
    endtask

    task automatic read_back(input logic bank);
        logic [OBJ_AW-1:0] idx;
        for (int i = 0; i < OBJ_WORDS; i++) begin
            idx = OBJ_AW'(i);
            @(posedge clk);
            rd_addr <= idx;
            @(posedge clk);               // Registered read.
            @(negedge clk);
            check_word($sformatf("rd_data[%0d]", i), rd_data, exp_mem[{bank, idx}]);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // SDRAM model, reply after the row latency unless withheld.
    always @(posedge clk) begin
        if (!oram_cs || oram_addr != last_addr) begin
            wait_clks <= 0;
        end else begin
            wait_clks <= wait_clks + 1;
        end
        last_addr <= oram_addr;
        oram_data <= rule_data(oram_addr);
        oram_ok   <= oram_cs && (oram_addr == last_addr)
                     && (wait_clks >= cur_lat * PXL_DIV)
                     && !in_range(int'(oram_addr[OBJ_AW-1:0]), cur_lo, cur_hi);
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        obank      = 1'b0;
        rd_addr    = '0;
        cur_lat    = 0;
        cur_lo     = 1;
        cur_hi     = 0;
        checks     = 0;
        errors     = 0;
        frame_errs = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("oram_cs", oram_cs, 1'b0);          // Idle after reset.
        check_bit("oram_clr", oram_clr, 1'b1);
        for (frame_no = 0; frame_no <= ROWS; frame_no++) begin
            if (frame_no > 0) begin
                wait_frame_edge();
            end
            check_bit("obank_frame", obank_frame, 1'(frame_no % 2)); // Counted frames.
            check_line("vdump", vdump, '0);               // Frame edge on line 0.
            check_bit("LVBL", LVBL, 1'b0);                // Top of frame is blanked.
            if (frame_no < ROWS) begin
                start_row(frame_no);
            end
            if (frame_no > 0) begin
                read_back(1'((frame_no - 1) % 2));    // Previous copy is shown.
            end
            if (frame_no < ROWS) begin
                wait_blank_edge(1'b1, VDUMP_W'(VB_END));     // Active area opens.
                do @(negedge clk); while (!oram_cs);
                check_line("vdump", vdump, VDUMP_W'(COPY_LINE));
                do @(negedge clk); while (oram_cs);
                check_bit("obank_frame", obank_frame, 1'(frame_no % 2)); // Same frame.
                wait_blank_edge(1'b0, VDUMP_W'(VB_START));   // Bottom blank starts.
                $display("frame %0d: obank %0d, latency %0d, withheld %0d..%0d, %0d errors",
                         frame_no, cur_row.obank, cur_row.lat, cur_row.skip_lo,
                         cur_row.skip_hi, frame_errs);
            end else begin
                $display("frame %0d: final read back, %0d errors", frame_no, frame_errs);
            end
            frame_errs = 0;
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
design/video_pkg.sv
design/obj_pkg.sv
design/video_timer.sv
design/oram_copy_ctrl.sv
design/obj_frame_buffer.sv
design/obj_dma_top.sv
dv/obj_dma_assert.sv
dv/obj_dma_tb.sv

//--- Makefile
# Verilator flow for the object table copy stage.

VERILATOR  ?= verilator
TOP        := obj_dma_tb
FILELIST   := src.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := RESULT: PASS

SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
